// ==== design/mem_ctrl_pkg.sv ====
// DESC_DEPTH must stay equal to 2**DESC_IDX_W and loop counts are at most 8 bits wide
package mem_ctrl_pkg;

  // ********************************************************************
  // widths
  // ********************************************************************
  localparam int ADDR_W     = 32;  // byte address
  localparam int TX_SIZE_W  = 10;  // request size field
  localparam int LOOP_W     = 8;   // loop count and loop max
  localparam int DESC_IDX_W = 3;
  localparam int DESC_DEPTH = 8;   // entries per descriptor table

  // ********************************************************************
  // scalar types
  // ********************************************************************
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [TX_SIZE_W-1:0] tx_size_t;

  // also used for the descriptor index counters, low bits only
  typedef logic [LOOP_W-1:0] loop_t;

  typedef logic [DESC_IDX_W-1:0] desc_idx_t;

endpackage

// ==== design/mem_desc_pkg.sv ====
// descriptor records as loaded into the tables; loop_max fields hold the request count minus one
package mem_desc_pkg;

  // ********************************************************************
  // read descriptor
  // ********************************************************************
  // buffer phase runs first, then the stream phase
  typedef struct packed {
    mem_ctrl_pkg::addr_t    buffer_base;
    mem_ctrl_pkg::addr_t    buffer_offset;    // byte stride
    mem_ctrl_pkg::loop_t    buffer_loop_max;  // requests minus one
    mem_ctrl_pkg::tx_size_t buffer_size;
    mem_ctrl_pkg::addr_t    stream_base;
    mem_ctrl_pkg::addr_t    stream_offset;    // byte stride
    mem_ctrl_pkg::loop_t    stream_loop_max;
    mem_ctrl_pkg::tx_size_t stream_size;
  } rd_desc_t;

  // ********************************************************************
  // write descriptor
  // ********************************************************************
  // one burst per descriptor, closed by wr_done
  typedef struct packed {
    mem_ctrl_pkg::addr_t    base;
    mem_ctrl_pkg::addr_t    offset;
    mem_ctrl_pkg::loop_t    loop_max;  // burst length minus one
    mem_ctrl_pkg::tx_size_t size;
  } wr_desc_t;

endpackage

// ==== design/loop_counter.sv ====
// count wraps to zero after reaching max and max may change only while the counter is idle
`timescale 1ns/1ps

module loop_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  logic                inc,
  input  mem_ctrl_pkg::loop_t max,
  output mem_ctrl_pkg::loop_t count,
  output logic                last
);

  // terminal value reached, next inc wraps
  assign last = (count == max);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (inc) begin
      if (last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // clear and inc come from different phases of the owning FSM
  a_no_inc_with_clear: assert property (
    @(posedge clk) disable iff (reset) !(inc && clear)
  );

endmodule

// ==== design/desc_table.sv ====
// registered read returns the old entry when load and read hit the same index in one cycle
`timescale 1ns/1ps

module desc_table #(
  parameter type entry_t = logic
) (
  input  logic                    clk,
  input  logic                    load,
  input  mem_ctrl_pkg::desc_idx_t load_idx,
  input  entry_t                  load_entry,
  input  mem_ctrl_pkg::desc_idx_t rd_idx,
  output entry_t                  entry
);

  // ********************************************************************
  // storage
  // ********************************************************************
  entry_t mem [mem_ctrl_pkg::DESC_DEPTH];

  // load port, one entry per strobe
  always_ff @(posedge clk) begin
    if (load) begin
      mem[load_idx] <= load_entry;
    end
  end

  // ********************************************************************
  // read stage
  // ********************************************************************
  // entry follows rd_idx by one cycle
  always_ff @(posedge clk) begin
    entry <= mem[rd_idx];
  end

endmodule

// ==== design/read_sequencer.sv ====
// reads of descriptor i are issued only once wr_idx has reached i and last_idx is held during a run
`timescale 1ns/1ps

module read_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  mem_ctrl_pkg::desc_idx_t last_idx,
  input  mem_ctrl_pkg::desc_idx_t wr_idx,
  output mem_ctrl_pkg::desc_idx_t desc_idx,
  input  mem_desc_pkg::rd_desc_t  desc,
  input  logic                    rd_ready,
  output logic                    rd_req,
  output mem_ctrl_pkg::addr_t     rd_addr,
  output mem_ctrl_pkg::tx_size_t  rd_size,
  output logic                    rd_buffer
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_BUFFER,
    RD_STREAM
  } rd_state_t;

  rd_state_t              state;
  logic                   fetch_wait;     // second fetch cycle with valid table output
  logic                   latch_desc;
  logic                   throttle_open;
  logic                   buf_req;
  logic                   strm_req;
  logic                   buf_last;
  logic                   strm_last;
  logic                   idx_last;
  logic                   desc_done;
  mem_ctrl_pkg::loop_t    idx_count;
  mem_ctrl_pkg::loop_t    idx_max;
  mem_desc_pkg::rd_desc_t desc_q;
  mem_ctrl_pkg::addr_t    buf_addr;
  mem_ctrl_pkg::addr_t    strm_addr;

  // ********************************************************************
  // request generation
  // ********************************************************************
  assign latch_desc    = (state == RD_FETCH) && fetch_wait;
  assign throttle_open = (desc_idx <= wr_idx);  // writes caught up with us
  assign buf_req       = (state == RD_BUFFER) && rd_ready && throttle_open;
  assign strm_req      = (state == RD_STREAM) && rd_ready && throttle_open;
  assign desc_done     = strm_req && strm_last;

  assign rd_req    = buf_req || strm_req;
  assign rd_buffer = (state == RD_BUFFER);
  assign rd_addr   = rd_buffer ? buf_addr : strm_addr;
  assign rd_size   = rd_buffer ? desc_q.buffer_size : desc_q.stream_size;

  // ********************************************************************
  // FSM
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= RD_IDLE;
      fetch_wait <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (start) state <= RD_FETCH;
        end
        RD_FETCH: begin
          fetch_wait <= !fetch_wait;
          if (fetch_wait) state <= RD_BUFFER;
        end
        RD_BUFFER: begin
          if (buf_req && buf_last) state <= RD_STREAM;
        end
        RD_STREAM: begin
          if (desc_done) begin
            if (idx_last) begin
              state <= RD_IDLE;   // whole table walked
            end else begin
              state <= RD_FETCH;
            end
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // descriptor and strided addresses
  always_ff @(posedge clk) begin
    if (latch_desc) begin
      desc_q    <= desc;
      buf_addr  <= desc.buffer_base;
      strm_addr <= desc.stream_base;
    end else begin
      if (buf_req) buf_addr <= buf_addr + desc_q.buffer_offset;
      if (strm_req) strm_addr <= strm_addr + desc_q.stream_offset;
    end
  end

  // ********************************************************************
  // loop and index counters
  // ********************************************************************
  loop_counter buf_loop_i (
    .clk   (clk),
    .reset (reset),
    .clear (latch_desc),
    .inc   (buf_req),
    .max   (desc_q.buffer_loop_max),
    .count (),
    .last  (buf_last)
  );

  loop_counter strm_loop_i (
    .clk   (clk),
    .reset (reset),
    .clear (latch_desc),
    .inc   (strm_req),
    .max   (desc_q.stream_loop_max),
    .count (),
    .last  (strm_last)
  );

  assign idx_max  = mem_ctrl_pkg::loop_t'(last_idx);
  assign desc_idx = idx_count[mem_ctrl_pkg::DESC_IDX_W-1:0];

  // wraps back to entry 0 after last_idx
  loop_counter idx_cnt_i (
    .clk   (clk),
    .reset (reset),
    .clear (1'b0),
    .inc   (desc_done),
    .max   (idx_max),
    .count (idx_count),
    .last  (idx_last)
  );

  // last_idx must hold while a run is in progress
  a_last_idx_stable: assert property (
    @(posedge clk) disable iff (reset) (state != RD_IDLE) |-> $stable(last_idx)
  );

endmodule

// ==== design/write_sequencer.sv ====
// wr_done is taken only after a finished burst and desc_idx stays at last_idx after done
`timescale 1ns/1ps

module write_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  mem_ctrl_pkg::desc_idx_t last_idx,
  output mem_ctrl_pkg::desc_idx_t desc_idx,
  input  mem_desc_pkg::wr_desc_t  desc,
  input  logic                    wr_ready,
  output logic                    wr_req,
  output mem_ctrl_pkg::addr_t     wr_addr,
  output mem_ctrl_pkg::tx_size_t  wr_size,
  input  logic                    wr_done,
  output logic                    done
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_FETCH,
    WR_BURST,
    WR_WAIT
  } wr_state_t;

  wr_state_t              state;
  logic                   fetch_wait;
  logic                   latch_desc;
  logic                   burst_last;
  logic                   idx_last;
  logic                   idx_clear;
  logic                   idx_inc;
  mem_ctrl_pkg::loop_t    idx_count;
  mem_ctrl_pkg::loop_t    idx_max;
  mem_desc_pkg::wr_desc_t desc_q;

  assign latch_desc = (state == WR_FETCH) && fetch_wait;
  assign wr_req     = (state == WR_BURST) && wr_ready;
  assign wr_size    = desc_q.size;

  // index stays on the last entry after done so trailing reads see an open throttle
  assign idx_clear = (state == WR_IDLE) && start;
  assign idx_inc   = (state == WR_WAIT) && wr_done && !idx_last;

  // ********************************************************************
  // FSM
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= WR_IDLE;
      fetch_wait <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= (state == WR_WAIT) && wr_done && idx_last;  // one cycle after final ack
      case (state)
        WR_IDLE: begin
          if (start) state <= WR_FETCH;
        end
        WR_FETCH: begin
          fetch_wait <= !fetch_wait;
          if (fetch_wait) state <= WR_BURST;
        end
        WR_BURST: begin
          if (wr_req && burst_last) state <= WR_WAIT;
        end
        WR_WAIT: begin
          if (wr_done) begin
            if (idx_last) begin
              state <= WR_IDLE;
            end else begin
              state <= WR_FETCH;
            end
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (latch_desc) begin
      desc_q  <= desc;
      wr_addr <= desc.base;
    end else if (wr_req) begin
      wr_addr <= wr_addr + desc_q.offset;  // next beat of the burst
    end
  end

  // ********************************************************************
  // counters
  // ********************************************************************
  loop_counter burst_cnt_i (
    .clk   (clk),
    .reset (reset),
    .clear (latch_desc),
    .inc   (wr_req),
    .max   (desc_q.loop_max),
    .count (),
    .last  (burst_last)
  );

  assign idx_max  = mem_ctrl_pkg::loop_t'(last_idx);
  assign desc_idx = idx_count[mem_ctrl_pkg::DESC_IDX_W-1:0];

  loop_counter idx_cnt_i (
    .clk   (clk),
    .reset (reset),
    .clear (idx_clear),
    .inc   (idx_inc),
    .max   (idx_max),
    .count (idx_count),
    .last  (idx_last)
  );

  // last_idx must hold while a run is in progress
  a_last_idx_stable: assert property (
    @(posedge clk) disable iff (reset) (state != WR_IDLE) |-> $stable(last_idx)
  );

  // memory side may ack only a finished burst
  a_done_in_wait: assert property (
    @(posedge clk) disable iff (reset) wr_done |-> (state == WR_WAIT)
  );

endmodule

// ==== design/mem_ctrl_top.sv ====
// tables may be loaded only while both sequencers are idle and start is a single-cycle strobe
`timescale 1ns/1ps

module mem_ctrl_top (
  input  logic                    clk,
  input  logic                    reset,
  // descriptor loading
  input  logic                    rd_desc_load,
  input  mem_ctrl_pkg::desc_idx_t rd_desc_idx,
  input  mem_desc_pkg::rd_desc_t  rd_desc,
  input  logic                    wr_desc_load,
  input  mem_ctrl_pkg::desc_idx_t wr_desc_idx,
  input  mem_desc_pkg::wr_desc_t  wr_desc,
  input  mem_ctrl_pkg::desc_idx_t rd_last_idx,
  input  mem_ctrl_pkg::desc_idx_t wr_last_idx,
  // run control
  input  logic                    start,
  output logic                    done,
  // read side
  input  logic                    rd_ready,
  output logic                    rd_req,
  output mem_ctrl_pkg::addr_t     rd_addr,
  output mem_ctrl_pkg::tx_size_t  rd_size,
  output logic                    rd_buffer,
  // write side
  input  logic                    wr_ready,
  output logic                    wr_req,
  output mem_ctrl_pkg::addr_t     wr_addr,
  output mem_ctrl_pkg::tx_size_t  wr_size,
  input  logic                    wr_done
);

  mem_ctrl_pkg::desc_idx_t rd_tbl_idx;
  mem_desc_pkg::rd_desc_t  rd_tbl_entry;
  mem_ctrl_pkg::desc_idx_t wr_tbl_idx;   // also the throttle reference
  mem_desc_pkg::wr_desc_t  wr_tbl_entry;

  // ********************************************************************
  // descriptor tables
  // ********************************************************************
  desc_table #(.entry_t(mem_desc_pkg::rd_desc_t)) rd_table_i (
    .clk        (clk),
    .load       (rd_desc_load),
    .load_idx   (rd_desc_idx),
    .load_entry (rd_desc),
    .rd_idx     (rd_tbl_idx),
    .entry      (rd_tbl_entry)
  );

  desc_table #(.entry_t(mem_desc_pkg::wr_desc_t)) wr_table_i (
    .clk        (clk),
    .load       (wr_desc_load),
    .load_idx   (wr_desc_idx),
    .load_entry (wr_desc),
    .rd_idx     (wr_tbl_idx),
    .entry      (wr_tbl_entry)
  );

  // ********************************************************************
  // sequencers
  // ********************************************************************
  read_sequencer rd_seq_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .last_idx  (rd_last_idx),
    .wr_idx    (wr_tbl_idx),
    .desc_idx  (rd_tbl_idx),
    .desc      (rd_tbl_entry),
    .rd_ready  (rd_ready),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_size   (rd_size),
    .rd_buffer (rd_buffer)
  );

  write_sequencer wr_seq_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .last_idx (wr_last_idx),
    .desc_idx (wr_tbl_idx),
    .desc     (wr_tbl_entry),
    .wr_ready (wr_ready),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_size  (wr_size),
    .wr_done  (wr_done),
    .done     (done)
  );

endmodule

// ==== sim/mem_ctrl_tb.sv ====
// run from the project root so the testdata path resolves and keep rd_last_idx at or below wr_last_idx
`timescale 1ns/1ps

module mem_ctrl_tb;

  localparam int TAIL_CYCLES = 8;  // quiet window after each run

  logic                    clk;
  logic                    reset;
  logic                    rd_desc_load;
  mem_ctrl_pkg::desc_idx_t rd_desc_idx;
  mem_desc_pkg::rd_desc_t  rd_desc;
  logic                    wr_desc_load;
  mem_ctrl_pkg::desc_idx_t wr_desc_idx;
  mem_desc_pkg::wr_desc_t  wr_desc;
  mem_ctrl_pkg::desc_idx_t rd_last_idx;
  mem_ctrl_pkg::desc_idx_t wr_last_idx;
  logic                    start;
  logic                    done;
  logic                    rd_ready;
  logic                    rd_req;
  mem_ctrl_pkg::addr_t     rd_addr;
  mem_ctrl_pkg::tx_size_t  rd_size;
  logic                    rd_buffer;
  logic                    wr_ready;
  logic                    wr_req;
  mem_ctrl_pkg::addr_t     wr_addr;
  mem_ctrl_pkg::tx_size_t  wr_size;
  logic                    wr_done;

  // expected request streams, oldest first
  mem_ctrl_pkg::addr_t    exp_rd_addr[$];
  mem_ctrl_pkg::tx_size_t exp_rd_size[$];
  logic                   exp_rd_buf[$];
  int                     exp_rd_desc[$];  // descriptor each read belongs to
  mem_ctrl_pkg::addr_t    exp_wr_addr[$];
  mem_ctrl_pkg::tx_size_t exp_wr_size[$];
  int                     exp_wr_len[$];   // burst length per write descriptor

  logic [31:0] rng;
  logic [31:0] fld [8];
  int          fd;
  int          ready_pct;
  int          dly_min;
  int          dly_max;
  int          value_errs;
  int          other_errs;
  int          checks;
  logic        timed_out;

  mem_ctrl_top mem_ctrl_top_i (
    .clk          (clk),
    .reset        (reset),
    .rd_desc_load (rd_desc_load),
    .rd_desc_idx  (rd_desc_idx),
    .rd_desc      (rd_desc),
    .wr_desc_load (wr_desc_load),
    .wr_desc_idx  (wr_desc_idx),
    .wr_desc      (wr_desc),
    .rd_last_idx  (rd_last_idx),
    .wr_last_idx  (wr_last_idx),
    .start        (start),
    .done         (done),
    .rd_ready     (rd_ready),
    .rd_req       (rd_req),
    .rd_addr      (rd_addr),
    .rd_size      (rd_size),
    .rd_buffer    (rd_buffer),
    .wr_ready     (wr_ready),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_size      (wr_size),
    .wr_done      (wr_done)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  // ********************************************************************
  // helpers
  // ********************************************************************
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll(input int modulo, output int val);
    rng = xorshift32(rng);
    val = int'(rng[15:0]) % modulo;
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    value_errs++;
    $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic other_error(input string msg);
    other_errs++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // strided rules, buffer phase then stream phase
  task automatic expect_reads(input int idx, input mem_desc_pkg::rd_desc_t e);
    for (int k = 0; k <= int'(e.buffer_loop_max); k++) begin
      exp_rd_addr.push_back(e.buffer_base + mem_ctrl_pkg::addr_t'(k) * e.buffer_offset);
      exp_rd_size.push_back(e.buffer_size);
      exp_rd_buf.push_back(1'b1);
      exp_rd_desc.push_back(idx);
    end
    for (int k = 0; k <= int'(e.stream_loop_max); k++) begin
      exp_rd_addr.push_back(e.stream_base + mem_ctrl_pkg::addr_t'(k) * e.stream_offset);
      exp_rd_size.push_back(e.stream_size);
      exp_rd_buf.push_back(1'b0);
      exp_rd_desc.push_back(idx);
    end
  endtask

  task automatic expect_writes(input mem_desc_pkg::wr_desc_t e);
    for (int k = 0; k <= int'(e.loop_max); k++) begin
      exp_wr_addr.push_back(e.base + mem_ctrl_pkg::addr_t'(k) * e.offset);
      exp_wr_size.push_back(e.size);
    end
    exp_wr_len.push_back(int'(e.loop_max) + 1);
  endtask

  // ********************************************************************
  // descriptor loading from the data file
  // ********************************************************************
  task automatic load_run();
    int n;
    mem_desc_pkg::rd_desc_t rd_e;
    mem_desc_pkg::wr_desc_t wr_e;
    n = $fscanf(fd, "%h %h", fld[0], fld[1]);
    if (n != 2) other_error("testdata file ended before a run header");
    rd_last_idx = mem_ctrl_pkg::desc_idx_t'(fld[0]);
    wr_last_idx = mem_ctrl_pkg::desc_idx_t'(fld[1]);
    for (int i = 0; i <= int'(rd_last_idx); i++) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3],
                  fld[4], fld[5], fld[6], fld[7]);
      if (n != 8) other_error("testdata file ended inside the read descriptors");
      rd_e.buffer_base     = fld[0];
      rd_e.buffer_offset   = fld[1];
      rd_e.buffer_loop_max = mem_ctrl_pkg::loop_t'(fld[2]);
      rd_e.buffer_size     = mem_ctrl_pkg::tx_size_t'(fld[3]);
      rd_e.stream_base     = fld[4];
      rd_e.stream_offset   = fld[5];
      rd_e.stream_loop_max = mem_ctrl_pkg::loop_t'(fld[6]);
      rd_e.stream_size     = mem_ctrl_pkg::tx_size_t'(fld[7]);
      @(negedge clk);
      rd_desc_load = 1'b1;
      rd_desc_idx  = mem_ctrl_pkg::desc_idx_t'(i);
      rd_desc      = rd_e;
      expect_reads(i, rd_e);
    end
    for (int i = 0; i <= int'(wr_last_idx); i++) begin
      n = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
      if (n != 4) other_error("testdata file ended inside the write descriptors");
      wr_e.base     = fld[0];
      wr_e.offset   = fld[1];
      wr_e.loop_max = mem_ctrl_pkg::loop_t'(fld[2]);
      wr_e.size     = mem_ctrl_pkg::tx_size_t'(fld[3]);
      @(negedge clk);
      rd_desc_load = 1'b0;
      wr_desc_load = 1'b1;
      wr_desc_idx  = mem_ctrl_pkg::desc_idx_t'(i);
      wr_desc      = wr_e;
      expect_writes(wr_e);
    end
    @(negedge clk);
    wr_desc_load = 1'b0;
  endtask

  // ********************************************************************
  // one run, driven on the falling edge and sampled 1 ns later
  // ********************************************************************
  task automatic run_seq();
    int   limit;
    int   cycles;
    int   acks;       // wr_done pulses already taken by the DUT
    int   n_wr_desc;
    int   burst_seen;
    int   ack_wait;
    int   done_count;
    int   quiet;
    int   r;
    logic in_wait;
    logic ack_now;
    n_wr_desc  = exp_wr_len.size();
    limit      = 20 * (exp_rd_addr.size() + exp_wr_addr.size()) + n_wr_desc * dly_max
                 + TAIL_CYCLES;
    cycles     = 0;
    acks       = 0;
    burst_seen = 0;
    ack_wait   = 0;
    done_count = 0;
    quiet      = 0;
    in_wait    = 1'b0;
    @(negedge clk);
    start = 1'b1;
    while (quiet < TAIL_CYCLES && !timed_out) begin
      roll(100, r);
      rd_ready = (r < ready_pct);
      roll(100, r);
      wr_ready = (r < ready_pct);
      wr_done  = 1'b0;
      if (in_wait) begin
        if (ack_wait == 0) begin
          wr_done = 1'b1;  // memory side finished the burst
          in_wait = 1'b0;
        end else begin
          ack_wait--;
        end
      end
      ack_now = wr_done;
      #1;
      if (rd_req && !rd_ready) other_error("rd_req high while rd_ready low");
      if (wr_req && !wr_ready) other_error("wr_req high while wr_ready low");
      if (rd_req) begin
        if (exp_rd_addr.size() == 0) begin
          other_error("read request after all expected reads were seen");
        end else begin
          checks++;
          if (rd_addr !== exp_rd_addr[0]) value_error("rd_addr", rd_addr, exp_rd_addr[0]);
          if (rd_size !== exp_rd_size[0]) begin
            value_error("rd_size", 32'(rd_size), 32'(exp_rd_size[0]));
          end
          if (rd_buffer !== exp_rd_buf[0]) begin
            value_error("rd_buffer", 32'(rd_buffer), 32'(exp_rd_buf[0]));
          end
          if (exp_rd_desc[0] > acks) begin
            other_error($sformatf("read of descriptor %0d issued after only %0d wr_done",
                                  exp_rd_desc[0], acks));
          end
          exp_rd_addr.delete(0);
          exp_rd_size.delete(0);
          exp_rd_buf.delete(0);
          exp_rd_desc.delete(0);
        end
      end
      if (wr_req) begin
        if (in_wait || ack_now) begin
          other_error("write request between the end of a burst and its wr_done");
        end else if (exp_wr_addr.size() == 0) begin
          other_error("write request after all expected writes were seen");
        end else begin
          checks++;
          if (wr_addr !== exp_wr_addr[0]) value_error("wr_addr", wr_addr, exp_wr_addr[0]);
          if (wr_size !== exp_wr_size[0]) begin
            value_error("wr_size", 32'(wr_size), 32'(exp_wr_size[0]));
          end
          exp_wr_addr.delete(0);
          exp_wr_size.delete(0);
          burst_seen++;
          if (burst_seen == exp_wr_len[0]) begin
            exp_wr_len.delete(0);
            burst_seen = 0;
            in_wait    = 1'b1;
            roll(dly_max - dly_min + 1, r);
            ack_wait = dly_min + r;
          end
        end
      end
      if (done) begin
        done_count++;
        if (done_count > 1) other_error("done pulsed more than once in one run");
        if (exp_wr_addr.size() != 0 || acks != n_wr_desc) begin
          other_error("done came before the final wr_done");
        end
      end
      if (ack_now) acks++;
      if (done_count > 0 && exp_rd_addr.size() == 0) quiet++;  // drained, watch for strays
      cycles++;
      if (cycles > limit) begin
        timed_out = 1'b1;
        other_error($sformatf("timeout, run not finished after %0d cycles", limit));
      end
      @(negedge clk);
      start = 1'b0;
    end
  endtask

  // ********************************************************************
  // main sequence
  // ********************************************************************
  initial begin
    int n;
    rng          = 32'hb477_f741;
    value_errs   = 0;
    other_errs   = 0;
    checks       = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    rd_desc_load = 1'b0;
    rd_desc_idx  = '0;
    rd_desc      = '0;
    wr_desc_load = 1'b0;
    wr_desc_idx  = '0;
    wr_desc      = '0;
    rd_last_idx  = '0;
    wr_last_idx  = '0;
    rd_ready     = 1'b0;
    wr_ready     = 1'b0;
    wr_done      = 1'b0;
    ready_pct    = 0;
    dly_min      = 0;
    dly_max      = 0;
    fd = $fopen("sim/mem_ctrl_testdata.txt", "r");
    if (fd == 0) begin
      other_error("cannot open sim/mem_ctrl_testdata.txt");
    end else begin
      n = $fscanf(fd, "%d %d %d", ready_pct, dly_min, dly_max);
      if (n != 3) other_error("testdata file has no ready and delay settings");
    end
    repeat (4) @(negedge clk);
    reset = 1'b0;
    #1;
    if (done !== 1'b0 || rd_req !== 1'b0 || wr_req !== 1'b0) begin
      other_error("done, rd_req or wr_req not low after reset");
    end
    // second run reloads the tables and reuses both sequencers
    for (int run_no = 0; run_no < 2; run_no++) begin
      if (fd != 0 && !timed_out) begin
        load_run();
        run_seq();
      end
    end
    if (fd != 0) $fclose(fd);
    if (checks == 0) other_error("no requests were checked");
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/mem_ctrl_testdata.txt ====
70 0 6
3 3
00001000 00000040 3 040 00008000 00000100 2 100
00002000 00000020 0 020 00009000 00000080 4 080
00003000 00000010 5 010 0000a000 00000200 1 200
00004000 00000080 2 080 0000b000 00000040 0 040
00010000 00000040 3 040
00011000 00000100 1 100
00012000 00000020 5 020
00013000 00000080 0 080
4 5
20000000 00000400 1 3ff 28000000 00000004 6 004
20010000 fffffff0 3 010 28010000 00000008 2 008
20020000 00000000 2 100 28020000 00000200 0 200
20030000 00000100 0 100 28030000 00000010 3 010
fffffff0 00000010 2 010 28040000 00000020 1 020
30000000 00000200 2 200
30010000 00000010 4 010
30020000 fffffe00 1 200
30030000 00000040 0 040
30040000 00000080 3 080
30050000 00000001 7 001

// ==== all.f ====
design/mem_ctrl_pkg.sv
design/mem_desc_pkg.sv
design/loop_counter.sv
design/desc_table.sv
design/read_sequencer.sv
design/write_sequencer.sv
design/mem_ctrl_top.sv
sim/mem_ctrl_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_ctrl_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
